// File: src.f
src/mips_pkg.sv
src/alu_control.sv
src/alu.sv
src/branch_compare.sv
src/forward_unit.sv
src/execute.sv
src/exec_top.sv
test/clk_gen.sv
test/exec_properties.sv
test/exec_tb.sv

// File: src/alu.sv
module alu (
	input  mips_pkg::data_t     i_a,
	input  mips_pkg::data_t     i_b,
	input  mips_pkg::alu_ctrl_t i_ctrl,
	input  mips_pkg::shamt_t    i_shamt,
	output mips_pkg::data_t     o_result
);

	// ====================
	// compare flags
	// ====================
	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed   = ($signed(i_a) < $signed(i_b));
	assign lt_unsigned = (i_a < i_b);

	// ====================
	// function select
	// ====================
	always_comb begin
		case (i_ctrl)
			// add and sub wrap, no overflow detect
			mips_pkg::ALU_ADD: begin
				o_result = i_a + i_b;
			end
			mips_pkg::ALU_SUB: begin
				o_result = i_a - i_b;
			end
			mips_pkg::ALU_AND: begin
				o_result = i_a & i_b;
			end
			mips_pkg::ALU_OR: begin
				o_result = i_a | i_b;
			end
			mips_pkg::ALU_XOR: begin
				o_result = i_a ^ i_b;
			end
			mips_pkg::ALU_NOR: begin
				o_result = ~(i_a | i_b);
			end
			mips_pkg::ALU_SLT: begin
				o_result = {31'd0, lt_signed};
			end
			mips_pkg::ALU_SLTU: begin
				o_result = {31'd0, lt_unsigned};
			end
			// shifts act on b, amount from the shamt field
			mips_pkg::ALU_SLL: begin
				o_result = i_b << i_shamt;
			end
			mips_pkg::ALU_SRL: begin
				o_result = i_b >> i_shamt;
			end
			mips_pkg::ALU_SRA: begin
				o_result = $signed(i_b) >>> i_shamt;
			end
			mips_pkg::ALU_LUI: begin
				o_result = {i_b[15:0], 16'h0000};
			end
			default: begin
				o_result = i_a + i_b;
			end
		endcase
	end

endmodule

// File: src/alu_control.sv
module alu_control (
	input  mips_pkg::alu_op_t   i_aluop,
	input  mips_pkg::func_t     i_func,
	output mips_pkg::alu_ctrl_t o_alu_ctrl
);

	// function field decode for r-type
	mips_pkg::alu_ctrl_t rtype_ctrl;

	always_comb begin
		case (i_func)
			mips_pkg::FUNC_SLL:  rtype_ctrl = mips_pkg::ALU_SLL;
			mips_pkg::FUNC_SRL:  rtype_ctrl = mips_pkg::ALU_SRL;
			mips_pkg::FUNC_SRA:  rtype_ctrl = mips_pkg::ALU_SRA;
			mips_pkg::FUNC_ADD:  rtype_ctrl = mips_pkg::ALU_ADD;
			// no overflow trap, so addu is the same adder
			mips_pkg::FUNC_ADDU: rtype_ctrl = mips_pkg::ALU_ADD;
			mips_pkg::FUNC_SUB:  rtype_ctrl = mips_pkg::ALU_SUB;
			mips_pkg::FUNC_AND:  rtype_ctrl = mips_pkg::ALU_AND;
			mips_pkg::FUNC_OR:   rtype_ctrl = mips_pkg::ALU_OR;
			mips_pkg::FUNC_XOR:  rtype_ctrl = mips_pkg::ALU_XOR;
			mips_pkg::FUNC_NOR:  rtype_ctrl = mips_pkg::ALU_NOR;
			mips_pkg::FUNC_SLT:  rtype_ctrl = mips_pkg::ALU_SLT;
			mips_pkg::FUNC_SLTU: rtype_ctrl = mips_pkg::ALU_SLTU;
			default:             rtype_ctrl = mips_pkg::ALU_ADD;
		endcase
	end

	// immediate and memory ops map straight across
	always_comb begin
		case (i_aluop)
			mips_pkg::ALUOP_RTYPE: o_alu_ctrl = rtype_ctrl;
			mips_pkg::ALUOP_ADD:   o_alu_ctrl = mips_pkg::ALU_ADD;
			mips_pkg::ALUOP_AND:   o_alu_ctrl = mips_pkg::ALU_AND;
			mips_pkg::ALUOP_OR:    o_alu_ctrl = mips_pkg::ALU_OR;
			mips_pkg::ALUOP_XOR:   o_alu_ctrl = mips_pkg::ALU_XOR;
			mips_pkg::ALUOP_SLT:   o_alu_ctrl = mips_pkg::ALU_SLT;
			mips_pkg::ALUOP_SLTU:  o_alu_ctrl = mips_pkg::ALU_SLTU;
			mips_pkg::ALUOP_LUI:   o_alu_ctrl = mips_pkg::ALU_LUI;
			default:               o_alu_ctrl = mips_pkg::ALU_ADD;
		endcase
	end

endmodule

// File: src/branch_compare.sv
module branch_compare (
	input  mips_pkg::data_t i_a,
	input  mips_pkg::data_t i_b,
	input  mips_pkg::bop_t  i_bop,
	output logic            o_taken
);

	logic a_eq_b;
	logic a_neg;
	logic a_zero;

	assign a_eq_b = (i_a == i_b);
	// sign bit and zero test cover all four zero compares
	assign a_neg  = i_a[31];
	assign a_zero = (i_a == '0);

	always_comb begin
		case (i_bop)
			mips_pkg::BOP_EQ:  o_taken = a_eq_b;
			mips_pkg::BOP_NE:  o_taken = ~a_eq_b;
			mips_pkg::BOP_LEZ: o_taken = a_neg | a_zero;
			mips_pkg::BOP_GTZ: o_taken = ~a_neg & ~a_zero;
			mips_pkg::BOP_LTZ: o_taken = a_neg;
			mips_pkg::BOP_GEZ: o_taken = ~a_neg;
			default:           o_taken = 1'b0;
		endcase
	end

endmodule

// File: src/exec_top.sv
module exec_top (
	input  logic                i_clk,
	input  logic                i_nrst,
	// id/ex
	input  mips_pkg::data_t     i_data_pc4,
	input  mips_pkg::data_t     i_data_rs,
	input  mips_pkg::data_t     i_data_rt,
	input  mips_pkg::data_t     i_data_imm,
	input  mips_pkg::reg_addr_t i_addr_rs,
	input  mips_pkg::reg_addr_t i_addr_rt,
	input  mips_pkg::reg_addr_t i_addr_rd,
	input  mips_pkg::alu_op_t   i_con_aluop,
	input  logic                i_con_alusrc,
	input  logic                i_con_regdst,
	input  logic                i_con_link,
	input  logic                i_con_memread,
	input  logic                i_con_memwrite,
	input  mips_pkg::load_sel_t i_con_loadsel,
	input  logic                i_con_memtoreg,
	input  logic                i_con_regwrite,
	input  mips_pkg::bop_t      i_con_bop,
	// later stages
	input  mips_pkg::data_t     i_data_mem_load,
	input  mips_pkg::data_t     i_data_wb_result,
	input  mips_pkg::data_t     i_data_wb_load,
	input  mips_pkg::reg_addr_t i_addr_wb_rd,
	input  logic                i_con_wb_regwrite,
	input  logic                i_con_wb_memtoreg,
	// ex/mem
	output mips_pkg::data_t     o_data_pc4,
	output mips_pkg::data_t     o_data_alures,
	output mips_pkg::data_t     o_data_store,
	output mips_pkg::reg_addr_t o_addr_dest,
	output logic                o_con_memread,
	output logic                o_con_memwrite,
	output logic                o_con_memtoreg,
	output logic                o_con_regwrite,
	output logic                o_con_link,
	output mips_pkg::load_sel_t o_con_loadsel,
	output logic                o_branch_taken
);

	mips_pkg::fwd_sel_t fwd_a;
	mips_pkg::fwd_sel_t fwd_b;

	// ex/mem hop comes straight from the stage's own outputs
	forward_unit u_fwd (
		.i_addr_rs        (i_addr_rs),
		.i_addr_rt        (i_addr_rt),
		.i_addr_exmem_rd  (o_addr_dest),
		.i_addr_memwb_rd  (i_addr_wb_rd),
		.i_exmem_regwrite (o_con_regwrite),
		.i_exmem_memread  (o_con_memread),
		.i_memwb_regwrite (i_con_wb_regwrite),
		.i_memwb_memtoreg (i_con_wb_memtoreg),
		.o_fwd_a          (fwd_a),
		.o_fwd_b          (fwd_b)
	);

	execute u_exec (
		.i_clk            (i_clk),
		.i_nrst           (i_nrst),
		.i_data_pc4       (i_data_pc4),
		.i_data_rs        (i_data_rs),
		.i_data_rt        (i_data_rt),
		.i_data_imm       (i_data_imm),
		.i_addr_rt        (i_addr_rt),
		.i_addr_rd        (i_addr_rd),
		.i_data_exmem_alu (o_data_alures),
		.i_data_mem_load  (i_data_mem_load),
		.i_data_wb_result (i_data_wb_result),
		.i_data_wb_load   (i_data_wb_load),
		.i_fwd_a          (fwd_a),
		.i_fwd_b          (fwd_b),
		.i_con_aluop      (i_con_aluop),
		.i_con_alusrc     (i_con_alusrc),
		.i_con_regdst     (i_con_regdst),
		.i_con_link       (i_con_link),
		.i_con_memread    (i_con_memread),
		.i_con_memwrite   (i_con_memwrite),
		.i_con_memtoreg   (i_con_memtoreg),
		.i_con_regwrite   (i_con_regwrite),
		.i_con_loadsel    (i_con_loadsel),
		.i_con_bop        (i_con_bop),
		.o_data_pc4       (o_data_pc4),
		.o_data_alures    (o_data_alures),
		.o_data_store     (o_data_store),
		.o_addr_dest      (o_addr_dest),
		.o_con_memread    (o_con_memread),
		.o_con_memwrite   (o_con_memwrite),
		.o_con_memtoreg   (o_con_memtoreg),
		.o_con_regwrite   (o_con_regwrite),
		.o_con_link       (o_con_link),
		.o_con_loadsel    (o_con_loadsel),
		.o_branch_taken   (o_branch_taken)
	);

endmodule

// File: src/execute.sv
module execute (
	input  logic                  i_clk,
	input  logic                  i_nrst,
	input  mips_pkg::data_t       i_data_pc4,
	input  mips_pkg::data_t       i_data_rs,
	input  mips_pkg::data_t       i_data_rt,
	input  mips_pkg::data_t       i_data_imm,
	input  mips_pkg::reg_addr_t   i_addr_rt,
	input  mips_pkg::reg_addr_t   i_addr_rd,
	// bypass data
	input  mips_pkg::data_t       i_data_exmem_alu,
	input  mips_pkg::data_t       i_data_mem_load,
	input  mips_pkg::data_t       i_data_wb_result,
	input  mips_pkg::data_t       i_data_wb_load,
	input  mips_pkg::fwd_sel_t    i_fwd_a,
	input  mips_pkg::fwd_sel_t    i_fwd_b,
	// controls from decode
	input  mips_pkg::alu_op_t     i_con_aluop,
	input  logic                  i_con_alusrc,
	input  logic                  i_con_regdst,
	input  logic                  i_con_link,
	input  logic                  i_con_memread,
	input  logic                  i_con_memwrite,
	input  logic                  i_con_memtoreg,
	input  logic                  i_con_regwrite,
	input  mips_pkg::load_sel_t   i_con_loadsel,
	input  mips_pkg::bop_t        i_con_bop,
	// ex/mem register
	output mips_pkg::data_t       o_data_pc4,
	output mips_pkg::data_t       o_data_alures,
	output mips_pkg::data_t       o_data_store,
	output mips_pkg::reg_addr_t   o_addr_dest,
	output logic                  o_con_memread,
	output logic                  o_con_memwrite,
	output logic                  o_con_memtoreg,
	output logic                  o_con_regwrite,
	output logic                  o_con_link,
	output mips_pkg::load_sel_t   o_con_loadsel,
	output logic                  o_branch_taken
);

	// five-way operand source mux, shared by both operands
	function automatic mips_pkg::data_t fwd_mux(
		input mips_pkg::fwd_sel_t sel,
		input mips_pkg::data_t    reg_val,
		input mips_pkg::data_t    exmem_alu,
		input mips_pkg::data_t    mem_load,
		input mips_pkg::data_t    wb_result,
		input mips_pkg::data_t    wb_load
	);
		case (sel)
			mips_pkg::FWD_EXMEM_ALU: fwd_mux = exmem_alu;
			mips_pkg::FWD_MEMWB_RES: fwd_mux = wb_result;
			mips_pkg::FWD_MEM_LOAD:  fwd_mux = mem_load;
			mips_pkg::FWD_WB_LOAD:   fwd_mux = wb_load;
			default:                 fwd_mux = reg_val;
		endcase
	endfunction

	// ====================
	// operands
	// ====================
	mips_pkg::data_t     opnd_a;
	mips_pkg::data_t     opnd_b;
	mips_pkg::data_t     alu_b;
	mips_pkg::alu_ctrl_t alu_ctrl;
	mips_pkg::data_t     alu_result;
	mips_pkg::reg_addr_t dest;

	assign opnd_a = fwd_mux(i_fwd_a, i_data_rs, i_data_exmem_alu, i_data_mem_load,
		i_data_wb_result, i_data_wb_load);
	assign opnd_b = fwd_mux(i_fwd_b, i_data_rt, i_data_exmem_alu, i_data_mem_load,
		i_data_wb_result, i_data_wb_load);

	assign alu_b = i_con_alusrc ? i_data_imm : opnd_b;

	// link wins over regdst
	assign dest = i_con_link ? mips_pkg::LINK_REG :
		(i_con_regdst ? i_addr_rd : i_addr_rt);

	// ====================
	// submodules
	// ====================
	alu_control u_alu_ctrl (
		.i_aluop    (i_con_aluop),
		.i_func     (i_data_imm[5:0]),
		.o_alu_ctrl (alu_ctrl)
	);

	alu u_alu (
		.i_a      (opnd_a),
		.i_b      (alu_b),
		.i_ctrl   (alu_ctrl),
		.i_shamt  (i_data_imm[10:6]),
		.o_result (alu_result)
	);

	// branch uses forwarded b, never the immediate
	branch_compare u_branch (
		.i_a     (opnd_a),
		.i_b     (opnd_b),
		.i_bop   (i_con_bop),
		.o_taken (o_branch_taken)
	);

	// ====================
	// ex/mem register
	// ====================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			o_data_pc4     <= '0;
			o_data_alures  <= '0;
			o_data_store   <= '0;
			o_addr_dest    <= '0;
			o_con_memread  <= 1'b0;
			o_con_memwrite <= 1'b0;
			o_con_memtoreg <= 1'b0;
			o_con_regwrite <= 1'b0;
			o_con_link     <= 1'b0;
			o_con_loadsel  <= '0;
		end else begin
			o_data_pc4     <= i_data_pc4;
			o_data_alures  <= alu_result;
			o_data_store   <= opnd_b;
			o_addr_dest    <= dest;
			o_con_memread  <= i_con_memread;
			o_con_memwrite <= i_con_memwrite;
			o_con_memtoreg <= i_con_memtoreg;
			o_con_regwrite <= i_con_regwrite;
			o_con_link     <= i_con_link;
			o_con_loadsel  <= i_con_loadsel;
		end
	end

endmodule

// File: src/forward_unit.sv
module forward_unit (
	input  mips_pkg::reg_addr_t i_addr_rs,
	input  mips_pkg::reg_addr_t i_addr_rt,
	input  mips_pkg::reg_addr_t i_addr_exmem_rd,
	input  mips_pkg::reg_addr_t i_addr_memwb_rd,
	input  logic                i_exmem_regwrite,
	input  logic                i_exmem_memread,
	input  logic                i_memwb_regwrite,
	input  logic                i_memwb_memtoreg,
	output mips_pkg::fwd_sel_t  o_fwd_a,
	output mips_pkg::fwd_sel_t  o_fwd_b
);

	// ====================
	// per-operand select
	// ====================
	// ex/mem is checked first since it holds the newer value
	function automatic mips_pkg::fwd_sel_t pick_source(
		input mips_pkg::reg_addr_t src,
		input mips_pkg::reg_addr_t exmem_rd,
		input logic                exmem_wr,
		input logic                exmem_rd_mem,
		input mips_pkg::reg_addr_t memwb_rd,
		input logic                memwb_wr,
		input logic                memwb_mtr
	);
		pick_source = mips_pkg::FWD_REG;
		// $zero is hardwired, never bypass it
		if (src != '0) begin
			if (exmem_wr && (exmem_rd == src)) begin
				if (exmem_rd_mem) begin
					pick_source = mips_pkg::FWD_MEM_LOAD;
				end else begin
					pick_source = mips_pkg::FWD_EXMEM_ALU;
				end
			end else if (memwb_wr && (memwb_rd == src)) begin
				if (memwb_mtr) begin
					pick_source = mips_pkg::FWD_WB_LOAD;
				end else begin
					pick_source = mips_pkg::FWD_MEMWB_RES;
				end
			end
		end
	endfunction

	assign o_fwd_a = pick_source(i_addr_rs, i_addr_exmem_rd, i_exmem_regwrite,
		i_exmem_memread, i_addr_memwb_rd, i_memwb_regwrite, i_memwb_memtoreg);

	assign o_fwd_b = pick_source(i_addr_rt, i_addr_exmem_rd, i_exmem_regwrite,
		i_exmem_memread, i_addr_memwb_rd, i_memwb_regwrite, i_memwb_memtoreg);

endmodule

// File: src/mips_pkg.sv
package mips_pkg;

	// ====================
	// widths
	// ====================
	typedef logic [31:0] data_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  alu_op_t;
	typedef logic [5:0]  func_t;
	typedef logic [3:0]  alu_ctrl_t;
	typedef logic [2:0]  fwd_sel_t;
	typedef logic [2:0]  bop_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [1:0]  load_sel_t;

	// ====================
	// decode alu operations
	// ====================
	localparam alu_op_t ALUOP_ADD   = 6'd0;
	localparam alu_op_t ALUOP_RTYPE = 6'd1;
	localparam alu_op_t ALUOP_AND   = 6'd2;
	localparam alu_op_t ALUOP_OR    = 6'd3;
	localparam alu_op_t ALUOP_XOR   = 6'd4;
	localparam alu_op_t ALUOP_SLT   = 6'd5;
	localparam alu_op_t ALUOP_SLTU  = 6'd6;
	localparam alu_op_t ALUOP_LUI   = 6'd7;

	// r-type function field
	localparam func_t FUNC_SLL  = 6'h00;
	localparam func_t FUNC_SRL  = 6'h02;
	localparam func_t FUNC_SRA  = 6'h03;
	localparam func_t FUNC_ADD  = 6'h20;
	localparam func_t FUNC_ADDU = 6'h21;
	localparam func_t FUNC_SUB  = 6'h22;
	localparam func_t FUNC_AND  = 6'h24;
	localparam func_t FUNC_OR   = 6'h25;
	localparam func_t FUNC_XOR  = 6'h26;
	localparam func_t FUNC_NOR  = 6'h27;
	localparam func_t FUNC_SLT  = 6'h2A;
	localparam func_t FUNC_SLTU = 6'h2B;

	// ====================
	// alu function codes
	// ====================
	localparam alu_ctrl_t ALU_ADD  = 4'd0;
	localparam alu_ctrl_t ALU_SUB  = 4'd1;
	localparam alu_ctrl_t ALU_AND  = 4'd2;
	localparam alu_ctrl_t ALU_OR   = 4'd3;
	localparam alu_ctrl_t ALU_XOR  = 4'd4;
	localparam alu_ctrl_t ALU_NOR  = 4'd5;
	localparam alu_ctrl_t ALU_SLT  = 4'd6;
	localparam alu_ctrl_t ALU_SLTU = 4'd7;
	localparam alu_ctrl_t ALU_SLL  = 4'd8;
	localparam alu_ctrl_t ALU_SRL  = 4'd9;
	localparam alu_ctrl_t ALU_SRA  = 4'd10;
	localparam alu_ctrl_t ALU_LUI  = 4'd11;

	// operand sources, ordered by pipeline distance
	localparam fwd_sel_t FWD_REG       = 3'd0;
	localparam fwd_sel_t FWD_EXMEM_ALU = 3'd1;
	localparam fwd_sel_t FWD_MEMWB_RES = 3'd2;
	localparam fwd_sel_t FWD_MEM_LOAD  = 3'd3;
	localparam fwd_sel_t FWD_WB_LOAD   = 3'd4;

	// branch conditions
	localparam bop_t BOP_NONE = 3'd0;
	localparam bop_t BOP_EQ   = 3'd1;
	localparam bop_t BOP_NE   = 3'd2;
	localparam bop_t BOP_LEZ  = 3'd3;
	localparam bop_t BOP_GTZ  = 3'd4;
	localparam bop_t BOP_LTZ  = 3'd5;
	localparam bop_t BOP_GEZ  = 3'd6;

	// jal writes the return address here
	localparam reg_addr_t LINK_REG = 5'd31;

endpackage

// File: test/clk_gen.sv
module clk_gen (
	output logic o_clk,
	output logic o_nrst
);

	initial begin
		o_clk = 1'b0;
		forever #20 o_clk = ~o_clk;
	end

	// reset falls just after time zero and stays low for 8 rising edges
	initial begin
		o_nrst = 1'b1;
		#1 o_nrst = 1'b0;
		repeat (8) @(posedge o_clk);
		o_nrst <= 1'b1;
	end

endmodule

// File: test/exec_properties.sv
module exec_properties (
	input logic                i_clk,
	input logic                i_nrst,
	input mips_pkg::data_t     i_data_pc4, i_data_rs, i_data_rt, i_data_imm,
	input mips_pkg::reg_addr_t i_addr_rs, i_addr_rt, i_addr_rd, i_addr_wb_rd,
	input mips_pkg::alu_op_t   i_con_aluop,
	input logic                i_con_alusrc, i_con_regdst, i_con_link,
	input logic                i_con_memread, i_con_memwrite, i_con_memtoreg, i_con_regwrite,
	input mips_pkg::load_sel_t i_con_loadsel,
	input mips_pkg::bop_t      i_con_bop,
	input mips_pkg::data_t     i_data_mem_load, i_data_wb_result, i_data_wb_load,
	input logic                i_con_wb_regwrite, i_con_wb_memtoreg,
	input mips_pkg::data_t     o_data_pc4, o_data_alures, o_data_store,
	input mips_pkg::reg_addr_t o_addr_dest,
	input logic                o_con_memread, o_con_memwrite, o_con_memtoreg,
	input logic                o_con_regwrite, o_con_link,
	input mips_pkg::load_sel_t o_con_loadsel,
	input logic                o_branch_taken
);

	int fail_count = 0;

	mips_pkg::data_t     exp_a;
	mips_pkg::data_t     exp_b;
	mips_pkg::data_t     exp_alu;
	mips_pkg::reg_addr_t exp_dest;
	logic                exp_taken;

	// values expected one edge later, also the model's copy of ex/mem
	logic                prev_valid = 1'b0;
	mips_pkg::data_t     prev_pc4;
	mips_pkg::data_t     prev_alu;
	mips_pkg::data_t     prev_store;
	mips_pkg::reg_addr_t prev_dest;
	logic [6:0]          prev_ctrl;

	// ====================
	// reference model
	// ====================
	// newest writer wins, $zero never bypassed
	function automatic mips_pkg::data_t bypass(input mips_pkg::reg_addr_t src,
		input mips_pkg::data_t reg_val);
		if (src == 5'd0) begin
			return reg_val;
		end
		// ex/mem hop taken from the model's own register copy
		if (prev_ctrl[3] && (prev_dest == src)) begin
			return prev_ctrl[6] ? i_data_mem_load : prev_alu;
		end
		if (i_con_wb_regwrite && (i_addr_wb_rd == src)) begin
			return i_con_wb_memtoreg ? i_data_wb_load : i_data_wb_result;
		end
		return reg_val;
	endfunction

	function automatic mips_pkg::data_t alu_ref(input mips_pkg::alu_op_t op,
		input mips_pkg::func_t fn, input mips_pkg::data_t a, input mips_pkg::data_t b,
		input mips_pkg::shamt_t sh);
		mips_pkg::data_t r;
		r = a + b;
		case (op)
			mips_pkg::ALUOP_AND:  r = a & b;
			mips_pkg::ALUOP_OR:   r = a | b;
			mips_pkg::ALUOP_XOR:  r = a ^ b;
			mips_pkg::ALUOP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			mips_pkg::ALUOP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
			mips_pkg::ALUOP_LUI:  r = b << 16;
			mips_pkg::ALUOP_RTYPE: begin
				case (fn)
					mips_pkg::FUNC_SLL:  r = b << sh;
					mips_pkg::FUNC_SRL:  r = b >> sh;
					mips_pkg::FUNC_SRA:  r = $signed(b) >>> sh;
					mips_pkg::FUNC_SUB:  r = a - b;
					mips_pkg::FUNC_AND:  r = a & b;
					mips_pkg::FUNC_OR:   r = a | b;
					mips_pkg::FUNC_XOR:  r = a ^ b;
					mips_pkg::FUNC_NOR:  r = ~(a | b);
					mips_pkg::FUNC_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mips_pkg::FUNC_SLTU: r = (a < b) ? 32'd1 : 32'd0;
					default:             r = a + b;
				endcase
			end
			default: r = a + b;
		endcase
		return r;
	endfunction

	function automatic logic branch_ref(input mips_pkg::bop_t op,
		input mips_pkg::data_t a, input mips_pkg::data_t b);
		case (op)
			mips_pkg::BOP_EQ:  return a == b;
			mips_pkg::BOP_NE:  return a != b;
			mips_pkg::BOP_LEZ: return $signed(a) <= 0;
			mips_pkg::BOP_GTZ: return $signed(a) > 0;
			mips_pkg::BOP_LTZ: return $signed(a) < 0;
			mips_pkg::BOP_GEZ: return $signed(a) >= 0;
			default:           return 1'b0;
		endcase
	endfunction

	always_comb begin
		exp_a     = bypass(i_addr_rs, i_data_rs);
		exp_b     = bypass(i_addr_rt, i_data_rt);
		exp_alu   = alu_ref(i_con_aluop, i_data_imm[5:0], exp_a,
			i_con_alusrc ? i_data_imm : exp_b, i_data_imm[10:6]);
		exp_taken = branch_ref(i_con_bop, exp_a, exp_b);
		exp_dest  = i_con_link ? mips_pkg::LINK_REG : (i_con_regdst ? i_addr_rd : i_addr_rt);
	end

	// cleared with the stage so the ex/mem hop starts empty
	always @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			prev_valid <= 1'b0;
			prev_alu   <= '0;
			prev_dest  <= '0;
			prev_ctrl  <= '0;
		end else begin
			prev_valid <= 1'b1;
			prev_pc4   <= i_data_pc4;
			prev_alu   <= exp_alu;
			prev_store <= exp_b;
			prev_dest  <= exp_dest;
			prev_ctrl  <= {i_con_memread, i_con_memwrite, i_con_memtoreg, i_con_regwrite,
				i_con_link, i_con_loadsel};
		end
	end

	// ====================
	// assertions
	// ====================
	reset_clear: assert property (@(posedge i_clk) (!i_nrst || $rose(i_nrst)) |->
		(!o_con_memread && !o_con_memwrite && !o_con_regwrite && o_data_alures == '0))
	else begin
		$error("error reset outputs not clear, o_data_alures %h", $sampled(o_data_alures));
		fail_count++;
	end

	alu_result: assert property (@(posedge i_clk) disable iff (!i_nrst)
		prev_valid |-> o_data_alures == prev_alu)
	else begin
		$error("error o_data_alures got %h exp %h", $sampled(o_data_alures), $sampled(prev_alu));
		fail_count++;
	end

	store_data: assert property (@(posedge i_clk) disable iff (!i_nrst)
		prev_valid |-> o_data_store == prev_store)
	else begin
		$error("error o_data_store got %h exp %h", $sampled(o_data_store), $sampled(prev_store));
		fail_count++;
	end

	dest_addr: assert property (@(posedge i_clk) disable iff (!i_nrst)
		prev_valid |-> o_addr_dest == prev_dest)
	else begin
		$error("error o_addr_dest got %h exp %h", $sampled(o_addr_dest), $sampled(prev_dest));
		fail_count++;
	end

	pc4_pass: assert property (@(posedge i_clk) disable iff (!i_nrst)
		prev_valid |-> o_data_pc4 == prev_pc4)
	else begin
		$error("error o_data_pc4 got %h exp %h", $sampled(o_data_pc4), $sampled(prev_pc4));
		fail_count++;
	end

	// memread memwrite memtoreg regwrite link loadsel, msb first
	ctrl_pass: assert property (@(posedge i_clk) disable iff (!i_nrst)
		prev_valid |-> {o_con_memread, o_con_memwrite, o_con_memtoreg, o_con_regwrite,
		o_con_link, o_con_loadsel} == prev_ctrl)
	else begin
		$error("error o_con controls got %h exp %h", $sampled({o_con_memread, o_con_memwrite,
			o_con_memtoreg, o_con_regwrite, o_con_link, o_con_loadsel}), $sampled(prev_ctrl));
		fail_count++;
	end

	branch_taken: assert property (@(posedge i_clk) disable iff (!i_nrst)
		o_branch_taken == exp_taken)
	else begin
		$error("error o_branch_taken got %h exp %h", $sampled(o_branch_taken),
			$sampled(exp_taken));
		fail_count++;
	end

endmodule

// File: test/exec_tb.sv
module exec_tb;

	logic                i_clk;
	logic                i_nrst;
	mips_pkg::data_t     i_data_pc4, i_data_rs, i_data_rt, i_data_imm;
	mips_pkg::reg_addr_t i_addr_rs, i_addr_rt, i_addr_rd, i_addr_wb_rd;
	mips_pkg::alu_op_t   i_con_aluop;
	logic                i_con_alusrc, i_con_regdst, i_con_link, i_con_memread;
	logic                i_con_memwrite, i_con_memtoreg, i_con_regwrite;
	mips_pkg::load_sel_t i_con_loadsel;
	mips_pkg::bop_t      i_con_bop;
	mips_pkg::data_t     i_data_mem_load, i_data_wb_result, i_data_wb_load;
	logic                i_con_wb_regwrite, i_con_wb_memtoreg;
	mips_pkg::data_t     o_data_pc4, o_data_alures, o_data_store;
	mips_pkg::reg_addr_t o_addr_dest;
	logic                o_con_memread, o_con_memwrite, o_con_memtoreg;
	logic                o_con_regwrite, o_con_link;
	mips_pkg::load_sel_t o_con_loadsel;
	logic                o_branch_taken;

	int seed = 51014;
	int errors = 0;

	// last entry is an unused code and must decode as add
	localparam mips_pkg::func_t func_list [13] = '{mips_pkg::FUNC_SLL, mips_pkg::FUNC_SRL,
		mips_pkg::FUNC_SRA, mips_pkg::FUNC_ADD, mips_pkg::FUNC_ADDU, mips_pkg::FUNC_SUB,
		mips_pkg::FUNC_AND, mips_pkg::FUNC_OR, mips_pkg::FUNC_XOR, mips_pkg::FUNC_NOR,
		mips_pkg::FUNC_SLT, mips_pkg::FUNC_SLTU, 6'h3F};

	clk_gen u_clk (
		.o_clk  (i_clk),
		.o_nrst (i_nrst)
	);

	exec_top u_dut (.*);

	bind exec_top exec_properties u_props (.*);

	// small address pool so hazards happen often
	function automatic mips_pkg::reg_addr_t pick_addr();
		logic [1:0] r;
		r = 2'($random(seed));
		return (r == 2'd3) ? mips_pkg::LINK_REG : {3'b000, r};
	endfunction

	task automatic set_random_data();
		i_data_pc4       <= $random(seed);
		i_data_rs        <= $random(seed);
		i_data_rt        <= $random(seed);
		i_data_imm       <= $random(seed);
		i_data_mem_load  <= $random(seed);
		i_data_wb_result <= $random(seed);
		i_data_wb_load   <= $random(seed);
		i_addr_rs        <= pick_addr();
		i_addr_rt        <= pick_addr();
		i_addr_rd        <= pick_addr();
		i_addr_wb_rd     <= pick_addr();
	endtask

	task automatic set_bubble();
		i_con_aluop       <= mips_pkg::ALUOP_ADD;
		i_con_alusrc      <= 1'b0;
		i_con_regdst      <= 1'b0;
		i_con_link        <= 1'b0;
		i_con_memread     <= 1'b0;
		i_con_memwrite    <= 1'b0;
		i_con_loadsel     <= '0;
		i_con_memtoreg    <= 1'b0;
		i_con_regwrite    <= 1'b0;
		i_con_bop         <= mips_pkg::BOP_NONE;
		i_con_wb_regwrite <= 1'b0;
		i_con_wb_memtoreg <= 1'b0;
	endtask

	task automatic wait_for_reset();
		int n;
		for (n = 0; n < 20 && i_nrst !== 1'b1; n++) begin
			@(posedge i_clk);
		end
		if (i_nrst !== 1'b1) begin
			$display("timeout: reset was never released");
			errors++;
		end
	endtask

	// ====================
	// end of phase
	// ====================
	task automatic drain_pipeline();
		int n;
		@(posedge i_clk);
		set_bubble();
		for (n = 0; n < 10 && (o_con_regwrite !== 1'b0 || o_con_memread !== 1'b0); n++) begin
			@(posedge i_clk);
		end
		if (o_con_regwrite !== 1'b0 || o_con_memread !== 1'b0) begin
			$display("timeout: the EX/MEM register did not empty after a phase");
			errors++;
		end
	endtask

	initial begin
		int op;
		int f;
		int n;
		mips_pkg::data_t val;
		set_random_data();
		set_bubble();
		// memory and write controls held high so reset has to clear them
		i_con_memread  <= 1'b1;
		i_con_memwrite <= 1'b1;
		i_con_regwrite <= 1'b1;
		wait_for_reset();
		set_bubble();

		// every operation against every function field, writers idle
		for (op = 0; op < 9; op++) begin
			for (f = 0; f < 13; f++) begin
				@(posedge i_clk);
				set_random_data();
				val = $random(seed);
				i_data_rs      <= (f % 4 == 0) ? '0 : val;
				if (f % 3 == 0) begin
					i_data_rt <= val;
				end
				i_data_imm     <= {26'($random(seed)), func_list[f]};
				i_con_aluop    <= 6'(op);
				i_con_alusrc   <= val[0];
				i_con_regdst   <= val[1];
				i_con_link     <= val[2] & val[3];
				i_con_memread  <= val[4];
				i_con_memwrite <= val[5];
				i_con_memtoreg <= val[6];
				i_con_loadsel  <= val[8:7];
				i_con_bop      <= 3'(op + f);
			end
		end
		drain_pipeline();

		// random hazards from both later stages
		for (n = 0; n < 400; n++) begin
			@(posedge i_clk);
			set_random_data();
			val = $random(seed);
			i_con_aluop       <= 6'(val[3:0] % 9);
			i_data_imm        <= {26'($random(seed)), func_list[val[7:4] % 13]};
			i_con_alusrc      <= val[8];
			i_con_regdst      <= val[9];
			i_con_link        <= val[10] & val[11];
			i_con_memread     <= val[12];
			i_con_memwrite    <= val[13];
			i_con_memtoreg    <= val[14];
			i_con_regwrite    <= val[15] | val[16];
			i_con_loadsel     <= val[18:17];
			i_con_bop         <= val[21:19];
			i_con_wb_regwrite <= val[22] | val[23];
			i_con_wb_memtoreg <= val[24];
		end
		drain_pipeline();
		repeat (2) @(posedge i_clk);

		$display("run complete: %0d testbench errors, %0d assertion failures",
			errors, u_dut.u_props.fail_count);
		if (errors == 0 && u_dut.u_props.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
